// File: design/bfs_cmd_pkg.sv
package bfs_cmd_pkg;

  // Reorder buffer id and destination register carried with each search
  typedef logic [6:0] robid_t;
  typedef logic [5:0] rd_t;

  // Error cause reported on the writeback port
  typedef logic [4:0] ecause_t;

  localparam ecause_t ECAUSE_NONE           = 5'd0;
  localparam ecause_t ECAUSE_QUEUE_OVERFLOW = 5'd1;

  // Search core FSM
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    INIT        = 3'd1,
    NODE_HEADER = 3'd2,
    ADD_NEIGHS  = 3'd3,
    DRAIN       = 3'd4,
    RESULT      = 3'd5
  } core_state_e;

endpackage

// File: design/bfs_graph_pkg.sv
package bfs_graph_pkg;

  // Node record address in graph memory
  typedef logic [31:0] node_id_t;

  // Up to 15 neighbors per node
  typedef logic [3:0] neigh_ct_t;

  // First word of a frame
  typedef struct packed {
    logic      marked;
    logic [26:0] reserved;
    neigh_ct_t neigh_ct;
    node_id_t  node_id;
  } graph_hdr_t;

  // Following words, two neighbor ids each
  typedef struct packed {
    node_id_t neigh_hi;
    node_id_t neigh_lo;
  } graph_pair_t;

  // One 64-bit memory word, decoded by rfirst
  typedef union packed {
    graph_hdr_t  hdr;
    graph_pair_t pair;
  } graph_word_u;

endpackage

// File: design/bfs_ifs.sv
`timescale 1ns/1ps

// Command from the dispatcher to one search core
interface bfs_cmd_if;
  import bfs_cmd_pkg::*;
  import bfs_graph_pkg::*;

  logic     start;
  robid_t   robid;
  rd_t      rd;
  node_id_t from_node;
  node_id_t to_node;
  logic     busy;

  modport dispatch (output start, robid, rd, from_node, to_node, input busy);
  modport core (input start, robid, rd, from_node, to_node, output busy);
endinterface

// Core side of the shared graph memory port
interface bfs_mem_if;
  import bfs_graph_pkg::*;

  logic        req;
  node_id_t    addr;
  logic        sof;
  logic        grant;
  logic        rvalid;
  logic        rfirst;
  graph_word_u rdata;
  logic        rbuf_empty;

  modport core (output req, addr, sof, input grant, rvalid, rfirst, rdata, rbuf_empty);
  modport arbiter (input req, addr, sof, output grant, rvalid, rfirst, rdata, rbuf_empty);
endinterface

// Finished search waiting for writeback
interface bfs_result_if;
  import bfs_cmd_pkg::*;

  logic    valid;
  logic    error;
  ecause_t ecause;
  robid_t  robid;
  rd_t     rd;
  logic    found;
  logic    ack;

  modport core (output valid, error, ecause, robid, rd, found, input ack);
  modport drain (input valid, error, ecause, robid, rd, found, output ack);
endinterface

// File: design/bfs_queue.sv
`timescale 1ns/1ps

module bfs_queue #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear,
  input  logic                    enq_two,
  input  logic                    enq_one,
  input  bfs_graph_pkg::node_id_t enq_lo,
  input  bfs_graph_pkg::node_id_t enq_hi,
  input  logic                    deq,
  output bfs_graph_pkg::node_id_t head,
  output logic                    empty,
  output logic                    overflow
);
  import bfs_graph_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  node_id_t           mem [QUEUE_DEPTH];
  logic [IDX_W-1:0]   wr_ptr;
  logic [IDX_W-1:0]   wr_ptr_1;
  logic [IDX_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic [CNT_W:0]     space;
  logic [1:0]         n_req;
  logic [1:0]         n_acc;
  logic               do_deq;

  function automatic logic [IDX_W-1:0] bump(input logic [IDX_W-1:0] p);
    return (p == IDX_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign head     = mem[rd_ptr];
  assign do_deq   = deq & ~empty;
  assign wr_ptr_1 = bump(wr_ptr);

  // Free slots this cycle, counting the entry leaving at the head
  always_comb begin
    space    = (CNT_W + 1)'(QUEUE_DEPTH) - {1'b0, count} + {{CNT_W{1'b0}}, do_deq};
    n_req    = enq_two ? 2'd2 : {1'b0, enq_one};
    overflow = ({{(CNT_W - 1){1'b0}}, n_req} > space);
    n_acc    = overflow ? space[1:0] : n_req;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (n_acc == 2'd2)
        wr_ptr <= bump(wr_ptr_1);
      else if (n_acc == 2'd1)
        wr_ptr <= wr_ptr_1;
      if (do_deq)
        rd_ptr <= bump(rd_ptr);
      count <= count + CNT_W'(n_acc) - CNT_W'(do_deq);
    end
  end

  // Entries that do not fit are dropped
  always_ff @(posedge clk) begin
    if (n_acc != 2'd0)
      mem[wr_ptr] <= enq_lo;
    if (n_acc == 2'd2)
      mem[wr_ptr_1] <= enq_hi;
  end

endmodule

// File: design/bfs_core.sv
`timescale 1ns/1ps

module bfs_core #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  bfs_cmd_if.core    cmd,
  bfs_mem_if.core    mem,
  bfs_result_if.core res
);
  import bfs_cmd_pkg::*;
  import bfs_graph_pkg::*;

  core_state_e state;
  core_state_e state_nx;

  robid_t      robid_q;
  rd_t         rd_q;
  node_id_t    from_q;
  node_id_t    to_q;

  logic        found;
  logic        error;
  logic        first_req;
  neigh_ct_t   neigh_left;

  logic        q_clear;
  logic        enq_one;
  logic        enq_two;
  node_id_t    enq_lo;
  logic        deq;
  node_id_t    q_head;
  logic        q_empty;
  logic        q_overflow;

  graph_word_u word;
  logic        hdr_expand;
  logic        done;

  bfs_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (q_clear),
    .enq_two  (enq_two),
    .enq_one  (enq_one),
    .enq_lo   (enq_lo),
    .enq_hi   (word.pair.neigh_hi),
    .deq      (deq),
    .head     (q_head),
    .empty    (q_empty),
    .overflow (q_overflow)
  );

  assign word    = mem.rdata;
  assign q_clear = flush | (state == IDLE);

  // Unmarked header with neighbors opens a run of pair words
  assign hdr_expand = mem.rvalid & mem.rfirst & ~word.hdr.marked &
                      (word.hdr.neigh_ct != '0);
  assign done       = q_empty & mem.rbuf_empty;

  // Head of the frontier goes straight to memory
  assign mem.req  = ~q_empty & ((state == NODE_HEADER) | (state == ADD_NEIGHS));
  assign mem.addr = q_head;
  assign mem.sof  = first_req;
  assign deq      = mem.req & mem.grant;

  always_comb begin
    enq_one = 1'b0;
    enq_two = 1'b0;
    enq_lo  = word.pair.neigh_lo;
    if (state == INIT) begin
      enq_one = 1'b1;
      enq_lo  = from_q;
    end else if (state == ADD_NEIGHS && mem.rvalid) begin
      // Odd count leaves a single id in the last word
      enq_two = (neigh_left >= 4'd2);
      enq_one = (neigh_left == 4'd1);
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      IDLE:        if (cmd.start) state_nx = INIT;
      INIT:        state_nx = NODE_HEADER;
      NODE_HEADER: begin
        if (hdr_expand)
          state_nx = ADD_NEIGHS;
        else if (done)
          state_nx = RESULT;
      end
      ADD_NEIGHS: begin
        if (q_overflow)
          state_nx = DRAIN;
        else if (mem.rvalid && neigh_left <= 4'd2)
          state_nx = NODE_HEADER;
      end
      // Let outstanding frames arrive before reporting
      DRAIN:       if (mem.rbuf_empty) state_nx = RESULT;
      RESULT:      if (res.ack) state_nx = IDLE;
      default:     state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      found      <= 1'b0;
      error      <= 1'b0;
      first_req  <= 1'b0;
      neigh_left <= '0;
    end else if (flush) begin
      state     <= IDLE;
      first_req <= 1'b0;
    end else begin
      state <= state_nx;
      if (state == IDLE && cmd.start) begin
        found     <= 1'b0;
        error     <= 1'b0;
        first_req <= 1'b1;
      end
      if (deq) begin
        first_req <= 1'b0;
        if (q_head == to_q && !error)
          found <= 1'b1;
      end
      // Overflow wins over a match in the same cycle
      if (q_overflow) begin
        error <= 1'b1;
        found <= 1'b0;
      end
      if (state == NODE_HEADER && hdr_expand)
        neigh_left <= word.hdr.neigh_ct;
      else if (state == ADD_NEIGHS && mem.rvalid)
        neigh_left <= neigh_left - 4'd2;
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && cmd.start) begin
      robid_q <= cmd.robid;
      rd_q    <= cmd.rd;
      from_q  <= cmd.from_node;
      to_q    <= cmd.to_node;
    end
  end

  assign cmd.busy   = (state != IDLE);
  assign res.valid  = (state == RESULT);
  assign res.error  = error;
  assign res.ecause = error ? ECAUSE_QUEUE_OVERFLOW : ECAUSE_NONE;
  assign res.robid  = robid_q;
  assign res.rd     = rd_q;
  assign res.found  = found;

endmodule

// File: design/bfs_dispatch.sv
`timescale 1ns/1ps

module bfs_dispatch #(
  parameter int NUM_CORES = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    rename_valid,
  input  bfs_cmd_pkg::robid_t     rename_robid,
  input  bfs_cmd_pkg::rd_t        rename_rd,
  input  bfs_graph_pkg::node_id_t rename_op1,
  input  bfs_graph_pkg::node_id_t rename_op2,
  output logic                    rename_stall,
  bfs_cmd_if.dispatch             cmd [NUM_CORES]
);
  import bfs_cmd_pkg::*;
  import bfs_graph_pkg::*;

  logic [NUM_CORES-1:0] busy;
  logic [NUM_CORES-1:0] pend;
  logic [NUM_CORES-1:0] pick;
  logic                 accept;

  robid_t   robid_q;
  rd_t      rd_q;
  node_id_t from_q;
  node_id_t to_q;

  // Lowest-numbered idle core
  always_comb begin
    pick = '0;
    for (int i = NUM_CORES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  // Only one start in flight, so the payload registers are shared
  assign rename_stall = (&busy) | (|pend);
  assign accept       = rename_valid & ~rename_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pend <= '0;
    else if (flush)
      pend <= '0;
    else
      pend <= accept ? pick : '0;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      robid_q <= rename_robid;
      rd_q    <= rename_rd;
      from_q  <= rename_op1;
      to_q    <= rename_op2;
    end
  end

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_lane
    assign busy[g]          = cmd[g].busy;
    assign cmd[g].start     = pend[g];
    assign cmd[g].robid     = robid_q;
    assign cmd[g].rd        = rd_q;
    assign cmd[g].from_node = from_q;
    assign cmd[g].to_node   = to_q;
  end

endmodule

// File: design/bfs_mem_arbiter.sv
`timescale 1ns/1ps

module bfs_mem_arbiter #(
  parameter int NUM_CORES = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush,
  bfs_mem_if.arbiter                   lanes [NUM_CORES],
  output logic                         mem_req,
  output logic                         mem_sof,
  output bfs_graph_pkg::node_id_t      mem_addr,
  output logic [$clog2(NUM_CORES)-1:0] mem_tag,
  input  logic                         mem_ready,
  input  logic                         mem_rvalid,
  input  logic                         mem_rfirst,
  input  logic [$clog2(NUM_CORES)-1:0] mem_rtag,
  input  bfs_graph_pkg::graph_word_u   mem_rdata
);
  import bfs_graph_pkg::*;

  localparam int TAG_W = $clog2(NUM_CORES);
  localparam int CNT_W = 8;

  logic [NUM_CORES-1:0] req;
  logic [NUM_CORES-1:0] sof;
  logic [NUM_CORES-1:0] grant;
  logic [NUM_CORES-1:0] hit;
  logic [NUM_CORES-1:0] last;
  node_id_t             addr [NUM_CORES];
  logic [CNT_W-1:0]     outst [NUM_CORES];
  neigh_ct_t            left [NUM_CORES];

  logic [TAG_W-1:0]     ptr;
  logic [TAG_W-1:0]     sel;
  logic                 sel_ok;
  neigh_ct_t            pairs;

  // Round robin starting at ptr
  always_comb begin
    int idx;
    sel    = ptr;
    sel_ok = 1'b0;
    for (int k = NUM_CORES - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NUM_CORES;
      if (req[idx]) begin
        sel    = TAG_W'(idx);
        sel_ok = 1'b1;
      end
    end
  end

  assign mem_req  = sel_ok;
  assign mem_addr = addr[sel];
  assign mem_sof  = sof[sel];
  assign mem_tag  = sel;

  // Pair words that follow a header, ceil(neigh_ct / 2)
  assign pairs = mem_rdata.hdr.marked ? '0 :
                 {1'b0, mem_rdata.hdr.neigh_ct[3:1]} + {3'b0, mem_rdata.hdr.neigh_ct[0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ptr <= '0;
    else if (mem_req && mem_ready)
      ptr <= TAG_W'((int'(sel) + 1) % NUM_CORES);
  end

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_lane
    assign req[g]   = lanes[g].req;
    assign addr[g]  = lanes[g].addr;
    assign sof[g]   = lanes[g].sof;
    assign grant[g] = mem_ready & sel_ok & (sel == TAG_W'(g));
    assign hit[g]   = mem_rvalid & (mem_rtag == TAG_W'(g));

    assign lanes[g].grant      = grant[g];
    assign lanes[g].rvalid     = hit[g];
    assign lanes[g].rfirst     = mem_rfirst;
    assign lanes[g].rdata      = mem_rdata;
    assign lanes[g].rbuf_empty = (outst[g] == '0);

    // Last word of a frame closes one outstanding request
    assign last[g] = hit[g] & (mem_rfirst ? (pairs == '0) : (left[g] == 4'd1));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        outst[g] <= '0;
        left[g]  <= '0;
      end else if (flush) begin
        outst[g] <= '0;
        left[g]  <= '0;
      end else begin
        outst[g] <= outst[g] + CNT_W'(grant[g]) - CNT_W'(last[g]);
        if (hit[g])
          left[g] <= mem_rfirst ? pairs : left[g] - 4'd1;
      end
    end
  end

endmodule

// File: design/bfs_wb_arbiter.sv
`timescale 1ns/1ps

module bfs_wb_arbiter #(
  parameter int NUM_CORES = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    wb_stall,
  bfs_result_if.drain             results [NUM_CORES],
  output logic                    wb_valid,
  output logic                    wb_error,
  output logic                    wb_result,
  output bfs_cmd_pkg::ecause_t    wb_ecause,
  output bfs_cmd_pkg::robid_t     wb_robid,
  output bfs_cmd_pkg::rd_t        wb_rd
);
  import bfs_cmd_pkg::*;

  localparam int TAG_W = $clog2(NUM_CORES);

  logic [NUM_CORES-1:0] rvalid;
  logic [NUM_CORES-1:0] rerror;
  logic [NUM_CORES-1:0] rfound;
  ecause_t              recause [NUM_CORES];
  robid_t               rrobid [NUM_CORES];
  rd_t                  rrd [NUM_CORES];

  logic [TAG_W-1:0]     ptr;
  logic [TAG_W-1:0]     sel;
  logic [TAG_W-1:0]     owner;
  logic                 sel_ok;
  logic                 load;
  logic                 leave;

  always_comb begin
    int idx;
    sel    = ptr;
    sel_ok = 1'b0;
    for (int k = NUM_CORES - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NUM_CORES;
      if (rvalid[idx]) begin
        sel    = TAG_W'(idx);
        sel_ok = 1'b1;
      end
    end
  end

  // Output register is held while stalled
  assign leave = wb_valid & ~wb_stall;
  assign load  = ~wb_valid & sel_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      ptr      <= '0;
      owner    <= '0;
    end else if (flush) begin
      wb_valid <= 1'b0;
    end else if (leave) begin
      wb_valid <= 1'b0;
    end else if (load) begin
      wb_valid <= 1'b1;
      owner    <= sel;
      ptr      <= TAG_W'((int'(sel) + 1) % NUM_CORES);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      wb_error  <= rerror[sel];
      wb_result <= rfound[sel];
      wb_ecause <= recause[sel];
      wb_robid  <= rrobid[sel];
      wb_rd     <= rrd[sel];
    end
  end

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_lane
    assign rvalid[g]      = results[g].valid;
    assign rerror[g]      = results[g].error;
    assign rfound[g]      = results[g].found;
    assign recause[g]     = results[g].ecause;
    assign rrobid[g]      = results[g].robid;
    assign rrd[g]         = results[g].rd;
    assign results[g].ack = leave & (owner == TAG_W'(g));
  end

endmodule

// File: design/bfs_accel_top.sv
`timescale 1ns/1ps

module bfs_accel_top #(
  parameter int NUM_CORES   = 4,
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // Rename
  input  logic                         rename_valid,
  input  bfs_cmd_pkg::robid_t          rename_robid,
  input  bfs_cmd_pkg::rd_t             rename_rd,
  input  bfs_graph_pkg::node_id_t      rename_op1,
  input  bfs_graph_pkg::node_id_t      rename_op2,
  output logic                         rename_stall,
  // Writeback
  output logic                         wb_valid,
  output logic                         wb_error,
  output bfs_cmd_pkg::ecause_t         wb_ecause,
  output bfs_cmd_pkg::robid_t          wb_robid,
  output bfs_cmd_pkg::rd_t             wb_rd,
  output logic                         wb_result,
  input  logic                         wb_stall,
  // Graph memory
  output logic                         mem_req,
  output bfs_graph_pkg::node_id_t      mem_addr,
  output logic                         mem_sof,
  output logic [$clog2(NUM_CORES)-1:0] mem_tag,
  input  logic                         mem_ready,
  input  logic                         mem_rvalid,
  input  logic                         mem_rfirst,
  input  logic [$clog2(NUM_CORES)-1:0] mem_rtag,
  input  bfs_graph_pkg::graph_word_u   mem_rdata,
  input  logic                         rob_flush
);

  bfs_cmd_if    cmd_if [NUM_CORES] ();
  bfs_mem_if    mem_if [NUM_CORES] ();
  bfs_result_if res_if [NUM_CORES] ();

  bfs_dispatch #(.NUM_CORES(NUM_CORES)) dispatch_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (rob_flush),
    .rename_valid (rename_valid),
    .rename_robid (rename_robid),
    .rename_rd    (rename_rd),
    .rename_op1   (rename_op1),
    .rename_op2   (rename_op2),
    .rename_stall (rename_stall),
    .cmd          (cmd_if)
  );

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
    bfs_core #(.QUEUE_DEPTH(QUEUE_DEPTH)) core_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .flush (rob_flush),
      .cmd   (cmd_if[g]),
      .mem   (mem_if[g]),
      .res   (res_if[g])
    );
  end

  bfs_mem_arbiter #(.NUM_CORES(NUM_CORES)) mem_arbiter_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (rob_flush),
    .lanes      (mem_if),
    .mem_req    (mem_req),
    .mem_sof    (mem_sof),
    .mem_addr   (mem_addr),
    .mem_tag    (mem_tag),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rfirst (mem_rfirst),
    .mem_rtag   (mem_rtag),
    .mem_rdata  (mem_rdata)
  );

  bfs_wb_arbiter #(.NUM_CORES(NUM_CORES)) wb_arbiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (rob_flush),
    .wb_stall  (wb_stall),
    .results   (res_if),
    .wb_valid  (wb_valid),
    .wb_error  (wb_error),
    .wb_result (wb_result),
    .wb_ecause (wb_ecause),
    .wb_robid  (wb_robid),
    .wb_rd     (wb_rd)
  );

endmodule

// File: tests/bfs_mem_model.sv
`timescale 1ns/1ps

module bfs_mem_model #(
  parameter int NUM_CORES = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         gaps_en,
  input  logic                         hold_after_sof,
  input  logic                         mem_req,
  input  logic                         mem_sof,
  input  bfs_graph_pkg::node_id_t      mem_addr,
  input  logic [$clog2(NUM_CORES)-1:0] mem_tag,
  output logic                         mem_ready,
  output logic                         mem_rvalid,
  output logic                         mem_rfirst,
  output logic [$clog2(NUM_CORES)-1:0] mem_rtag,
  output bfs_graph_pkg::graph_word_u   mem_rdata
);
  import bfs_graph_pkg::*;

  localparam int NODES = 64;
  localparam int TAG_W = $clog2(NUM_CORES);

  // Graph contents, loaded by the testbench
  int               ct [NODES];
  node_id_t         nb [NODES][15];
  logic [NODES-1:0] visited [NUM_CORES];

  graph_word_u      rq_data [$];
  logic             rq_first [$];
  logic [TAG_W-1:0] rq_tag [$];
  logic [15:0]      lfsr = 16'd50;
  logic             held;
  logic             bit_r;
  logic             bit_v;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Header marks the node for this tag as soon as the frame is built
  task automatic take_request(input logic [TAG_W-1:0] tag, input node_id_t addr,
                              input logic sof);
    graph_word_u w;
    int          n;
    logic        marked;
    if (sof)
      visited[tag] = '0;
    n      = (addr < NODES) ? ct[addr[5:0]] : 0;
    marked = (addr < NODES) ? visited[tag][addr[5:0]] : 1'b0;
    w = '0;
    w.hdr.marked   = marked;
    w.hdr.neigh_ct = neigh_ct_t'(n);
    w.hdr.node_id  = addr;
    rq_data.push_back(w);
    rq_first.push_back(1'b1);
    rq_tag.push_back(tag);
    if (!marked && addr < NODES) begin
      visited[tag][addr[5:0]] = 1'b1;
      for (int k = 0; k < (n + 1) / 2; k++) begin
        w = '0;
        w.pair.neigh_lo = nb[addr[5:0]][2*k];
        if (2*k + 1 < n)
          w.pair.neigh_hi = nb[addr[5:0]][2*k+1];
        rq_data.push_back(w);
        rq_first.push_back(1'b0);
        rq_tag.push_back(tag);
      end
    end
  endtask

  initial begin
    mem_ready  = 1'b0;
    mem_rvalid = 1'b0;
    mem_rfirst = 1'b0;
    mem_rtag   = '0;
    mem_rdata  = '0;
    held       = 1'b0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      rq_data.delete();
      rq_first.delete();
      rq_tag.delete();
      held = 1'b0;
    end else if (mem_req && mem_ready) begin
      take_request(mem_tag, mem_addr, mem_sof);
      if (mem_sof && hold_after_sof)
        held = 1'b1;
    end
    #2;
    if (!hold_after_sof)
      held = 1'b0;
    bit_r = 1'b1;
    bit_v = 1'b1;
    if (gaps_en) begin
      lfsr  = lfsr_step(lfsr);
      bit_r = lfsr[0];
      lfsr  = lfsr_step(lfsr);
      bit_v = lfsr[0];
    end
    mem_ready  = rst_n && !held && bit_r;
    mem_rvalid = 1'b0;
    if (rst_n && rq_data.size() != 0 && bit_v) begin
      mem_rvalid = 1'b1;
      mem_rdata  = rq_data.pop_front();
      mem_rfirst = rq_first.pop_front();
      mem_rtag   = rq_tag.pop_front();
    end
  end

endmodule

// File: tests/bfs_props.sv
`timescale 1ns/1ps

module bfs_props #(
  parameter int NUM_CORES = 4
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 rob_flush,
  input logic                 rename_valid,
  input logic                 wb_valid,
  input logic                 wb_stall,
  input logic                 wb_error,
  input logic                 wb_result,
  input bfs_cmd_pkg::ecause_t wb_ecause,
  input bfs_cmd_pkg::robid_t  wb_robid,
  input bfs_cmd_pkg::rd_t     wb_rd,
  input logic                 mem_req,
  input logic                 rename_stall
);

  // Searches accepted at rename and not yet written back
  logic [7:0] inflight;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      inflight <= '0;
    else if (rob_flush)
      inflight <= '0;
    else
      inflight <= inflight + {7'b0, rename_valid && !rename_stall}
                           - {7'b0, wb_valid && !wb_stall};
  end

  // Stalled writeback keeps every field
  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid && wb_stall && !rob_flush) |=> (wb_valid &&
      $stable({wb_error, wb_result, wb_ecause, wb_robid, wb_rd})))
    else $error("writeback changed while stalled");

  a_flush_req: assert property (@(posedge clk) disable iff (!rst_n)
    rob_flush |=> !mem_req)
    else $error("memory request right after flush");

  a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (inflight >= 8'(NUM_CORES)) |-> rename_stall)
    else $error("rename not stalled with every core busy");

endmodule

bind bfs_accel_top bfs_props #(.NUM_CORES(NUM_CORES)) props_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .rob_flush    (rob_flush),
  .rename_valid (rename_valid),
  .wb_valid     (wb_valid),
  .wb_stall     (wb_stall),
  .wb_error     (wb_error),
  .wb_result    (wb_result),
  .wb_ecause    (wb_ecause),
  .wb_robid     (wb_robid),
  .wb_rd        (wb_rd),
  .mem_req      (mem_req),
  .rename_stall (rename_stall)
);

// File: tests/bfs_tb.sv
`timescale 1ns/1ps

module bfs_tb;
  import bfs_cmd_pkg::*;
  import bfs_graph_pkg::*;

  localparam int NUM_CORES = 4;
  localparam int NODES     = 64;
  localparam int MAX_CYC   = 20000;

  logic clk = 1'b0;
  logic rst_n;
  logic rename_valid, rename_stall, rob_flush;
  robid_t rename_robid;
  rd_t rename_rd;
  node_id_t rename_op1, rename_op2;
  logic wb_valid, wb_error, wb_result, wb_stall;
  ecause_t wb_ecause;
  robid_t wb_robid;
  rd_t wb_rd;
  logic mem_req, mem_sof, mem_ready, mem_rvalid, mem_rfirst;
  node_id_t mem_addr;
  logic [1:0] mem_tag, mem_rtag;
  graph_word_u mem_rdata;
  logic gaps_en, hold_after_sof, stall_rand;

  int g_ct [NODES];
  int g_nb [NODES][15];
  logic exp_pend [128];
  logic exp_res [128];
  logic exp_err [128];
  rd_t exp_rd [128];
  int n_pend, errors, checks, cycles, stretch;
  logic [15:0] lfsr = 16'd50;
  logic hold_prev;
  logic [19:0] prev_fields;

  bfs_accel_top #(.NUM_CORES(NUM_CORES), .QUEUE_DEPTH(8)) bfs_accel_top_inst (.*);

  bfs_mem_model #(.NUM_CORES(NUM_CORES)) mem_model_inst (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYC) begin
      $display("Timeout after %0d cycles with %0d searches pending", cycles, n_pend);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic draw_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  // Random stall stretches of 1 to 8 cycles
  always @(posedge clk) begin
    logic [2:0] len;
    #1;
    if (stall_rand) begin
      if (stretch == 0) begin
        wb_stall = draw_bit();
        for (int i = 0; i < 3; i++)
          len[i] = draw_bit();
        stretch = 1 + len;
      end else
        stretch--;
    end
  end

  // Writeback monitor
  always @(posedge clk) begin
    if (rst_n) begin
      if (hold_prev && (!wb_valid ||
          prev_fields != {wb_error, wb_result, wb_ecause, wb_robid, wb_rd})) begin
        $display("FAIL %0t: writeback fields changed while stalled", $time);
        errors++;
      end
      hold_prev   = wb_valid && wb_stall;
      prev_fields = {wb_error, wb_result, wb_ecause, wb_robid, wb_rd};
      if (wb_valid && !wb_stall) begin
        checks++;
        if (!exp_pend[wb_robid]) begin
          $display("Unexpected writeback for robid %0d at %0t", wb_robid, $time);
          errors++;
        end else begin
          exp_pend[wb_robid] = 1'b0;
          n_pend--;
          if (wb_result !== exp_res[wb_robid] || wb_error !== exp_err[wb_robid] ||
              wb_rd !== exp_rd[wb_robid] ||
              wb_ecause !== (exp_err[wb_robid] ? ECAUSE_QUEUE_OVERFLOW : ECAUSE_NONE)) begin
            $display("FAIL %0t: robid %0d got result %0b error %0b rd %0d, expected %0b %0b %0d",
                     $time, wb_robid, wb_result, wb_error, wb_rd,
                     exp_res[wb_robid], exp_err[wb_robid], exp_rd[wb_robid]);
            errors++;
          end
        end
      end
    end
  end

  function automatic logic reach(input int from, input int to);
    bit seen [NODES];
    int q[$];
    int n;
    if (from == to)
      return 1'b1;
    seen[from] = 1'b1;
    q.push_back(from);
    while (q.size() != 0) begin
      n = q.pop_front();
      for (int k = 0; k < g_ct[n]; k++) begin
        if (g_nb[n][k] == to)
          return 1'b1;
        if (!seen[g_nb[n][k]]) begin
          seen[g_nb[n][k]] = 1'b1;
          q.push_back(g_nb[n][k]);
        end
      end
    end
    return 1'b0;
  endfunction

  task automatic add_edge(input int a, input int b);
    g_nb[a][g_ct[a]] = b;
    g_ct[a]++;
    mem_model_inst.ct[a] = g_ct[a];
    mem_model_inst.nb[a][g_ct[a]-1] = node_id_t'(b);
  endtask

  // Chain, cyclic part, separate pair, tree, and a 15-way star
  task automatic build_graph();
    for (int i = 0; i < NODES; i++)
      mem_model_inst.ct[i] = 0;
    for (int i = 0; i < 5; i++)
      add_edge(i, i + 1);
    add_edge(10, 11);
    add_edge(11, 11);
    add_edge(11, 12);
    add_edge(12, 10);
    add_edge(20, 21);
    add_edge(30, 31);
    add_edge(30, 32);
    add_edge(31, 33);
    add_edge(32, 34);
    for (int i = 41; i < 56; i++)
      add_edge(40, i);
  endtask

  task automatic issue(input int robid, input int from, input int to, input logic err);
    @(posedge clk);
    #1;
    while (rename_stall) begin
      @(posedge clk);
      #1;
    end
    rename_valid = 1'b1;
    rename_robid = robid_t'(robid);
    rename_rd    = rd_t'(robid * 5);
    rename_op1   = node_id_t'(from);
    rename_op2   = node_id_t'(to);
    exp_pend[robid] = 1'b1;
    exp_err[robid]  = err;
    exp_res[robid]  = err ? 1'b0 : reach(from, to);
    exp_rd[robid]   = rd_t'(robid * 5);
    n_pend++;
    @(posedge clk);
    #1;
    rename_valid = 1'b0;
  endtask

  task automatic wait_all();
    while (n_pend != 0)
      @(posedge clk);
    repeat (5) @(posedge clk);
    #1;
  endtask

  task automatic test_chain();
    issue(1, 0, 5, 1'b0);
    wait_all();
    issue(2, 3, 3, 1'b0);
    issue(3, 5, 0, 1'b0);
    wait_all();
  endtask

  task automatic test_parts();
    issue(4, 10, 21, 1'b0);
    issue(5, 10, 12, 1'b0);
    issue(6, 20, 21, 1'b0);
    wait_all();
  endtask

  task automatic test_full();
    wb_stall = 1'b1;
    issue(7, 0, 4, 1'b0);
    issue(8, 10, 21, 1'b0);
    issue(9, 30, 34, 1'b0);
    issue(10, 20, 21, 1'b0);
    repeat (4) @(posedge clk);
    checks++;
    if (rename_stall !== 1'b1) begin
      $display("FAIL %0t: rename_stall low with four searches running", $time);
      errors++;
    end
    #1;
    wb_stall = 1'b0;
    issue(11, 31, 34, 1'b0);
    wait_all();
  endtask

  task automatic test_random();
    gaps_en    = 1'b1;
    stall_rand = 1'b1;
    issue(12, 0, 5, 1'b0);
    issue(13, 1, 0, 1'b0);
    issue(14, 10, 12, 1'b0);
    issue(15, 20, 10, 1'b0);
    issue(16, 30, 34, 1'b0);
    issue(17, 31, 34, 1'b0);
    wait_all();
    @(posedge clk);
    #1;
    stall_rand = 1'b0;
    gaps_en    = 1'b0;
    wb_stall   = 1'b0;
    wait_all();
  endtask

  task automatic test_overflow();
    hold_after_sof = 1'b1;
    issue(20, 40, 60, 1'b1);
    wait_all();
    hold_after_sof = 1'b0;
  endtask

  // Every core is held mid-search when the flush hits
  task automatic test_flush();
    hold_after_sof = 1'b1;
    issue(30, 0, 5, 1'b0);
    issue(31, 30, 34, 1'b0);
    issue(32, 10, 12, 1'b0);
    issue(33, 20, 21, 1'b0);
    repeat (10) @(posedge clk);
    while (mem_model_inst.rq_data.size() != 0 || mem_rvalid)
      @(posedge clk);
    #1;
    rob_flush = 1'b1;
    @(posedge clk);
    #1;
    rob_flush      = 1'b0;
    hold_after_sof = 1'b0;
    for (int r = 30; r < 34; r++)
      exp_pend[r] = 1'b0;
    n_pend         = 0;
    repeat (40) @(posedge clk);
    checks++;
    if (rename_stall !== 1'b0) begin
      $display("FAIL %0t: rename_stall still high after flush", $time);
      errors++;
    end
    issue(34, 0, 5, 1'b0);
    wait_all();
  endtask

  initial begin
    rst_n          = 1'b0;
    rename_valid   = 1'b0;
    rename_robid   = '0;
    rename_rd      = '0;
    rename_op1     = '0;
    rename_op2     = '0;
    rob_flush      = 1'b0;
    wb_stall       = 1'b0;
    gaps_en        = 1'b0;
    hold_after_sof = 1'b0;
    stall_rand     = 1'b0;
    n_pend         = 0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    stretch        = 0;
    hold_prev      = 1'b0;
    for (int i = 0; i < 128; i++)
      exp_pend[i] = 1'b0;
    build_graph();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_chain();
    test_parts();
    test_full();
    test_random();
    test_overflow();
    test_flush();
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: project.f
design/bfs_cmd_pkg.sv
design/bfs_graph_pkg.sv
design/bfs_ifs.sv
design/bfs_queue.sv
design/bfs_core.sv
design/bfs_dispatch.sv
design/bfs_mem_arbiter.sv
design/bfs_wb_arbiter.sv
design/bfs_accel_top.sv
tests/bfs_mem_model.sv
tests/bfs_props.sv
tests/bfs_tb.sv
